// File: source/mem_defs.svh
// bus widths, bank geometry, memory size and delay LFSR seed
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address and data widths of the AXI-Lite port
`define ADDR_W 32
`define DATA_W 32
`define STRB_W (`DATA_W / 8)

// banks are word interleaved, NUM_BANKS must be a power of two
`define NUM_BANKS 4

// word address bits inside one bank
`define BANK_AW 6

// total bytes over all banks, 1024 by default
`define MEM_BYTES (`NUM_BANKS * (1 << `BANK_AW) * `STRB_W)

// start value of the response delay LFSR, never zero
`define LFSR_SEED 4'b0001

`endif

// File: source/axi_pkg.sv
// AXI-Lite channel payload structs and response codes
`include "mem_defs.svh"

package axi_pkg;

	// shared by AR and AW
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
	} ax_t;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [`STRB_W-1:0] strb; // one bit per byte lane
	} w_t;

	typedef struct packed {
		logic [`DATA_W-1:0] data;
		logic [1:0]         resp;
	} r_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_t;

	// response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: source/mem_pkg.sv
// bank request, bank response and bank index types
`include "mem_defs.svh"

package mem_pkg;

	// bits needed to name one bank
	localparam int SEL_W = $clog2(`NUM_BANKS);

	typedef logic [SEL_W-1:0] bank_sel_t;

	// one access towards a bank
	typedef struct packed {
		logic                en;
		logic                we;    // low for a read
		logic [`BANK_AW-1:0] waddr; // word address inside the bank
		logic [`DATA_W-1:0]  wdata;
		logic [`STRB_W-1:0]  strb;
	} bank_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] rdata;
	} bank_rsp_t;

endpackage

// File: source/sram_bank.sv
// byte-strobed synchronous SRAM bank with registered read port
`timescale 1ns/1ps
`include "mem_defs.svh"

module sram_bank (
	input  logic               clk,
	input  mem_pkg::bank_req_t req_i,
	output mem_pkg::bank_rsp_t rsp_o
);

	localparam int DEPTH = 1 << `BANK_AW;

	logic [`DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (req_i.en) begin
			if (req_i.we) begin
				// only the strobed lanes change
				for (int b = 0; b < `STRB_W; b++) begin
					if (req_i.strb[b]) begin
						mem[req_i.waddr][8*b +: 8] <= req_i.wdata[8*b +: 8];
					end
				end
			end else begin
				rsp_o.rdata <= mem[req_i.waddr]; // held until the next read
			end
		end
	end

endmodule

// File: source/read_merge.sv
// return mux for the bank read words, driven by the registered bank index
`timescale 1ns/1ps
`include "mem_defs.svh"

module read_merge (
	input  mem_pkg::bank_rsp_t [`NUM_BANKS-1:0] rsp_i,
	input  mem_pkg::bank_sel_t                  sel_i,
	output logic [`DATA_W-1:0]                  rdata_o
);

	// and-or mux, each bank word only reaches the output through its own gate
	always_comb begin
		rdata_o = '0;
		for (int i = 0; i < `NUM_BANKS; i++) begin
			if (sel_i == mem_pkg::bank_sel_t'(i)) begin
				rdata_o = rdata_o | rsp_i[i].rdata;
			end
		end
	end

endmodule

// File: source/bank_router.sv
// address split, range check, per-bank request fan-out and read bank index register
`timescale 1ns/1ps
`include "mem_defs.svh"

module bank_router (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  mem_pkg::bank_req_t                   req_i,
	input  logic [`ADDR_W-1:0]                   req_addr_i,
	output logic                                 range_err_o,
	output mem_pkg::bank_req_t [`NUM_BANKS-1:0]  bank_req_o,
	output mem_pkg::bank_sel_t                   sel_o
);

	localparam int OFS_W = $clog2(`STRB_W); // byte offset inside a word

	mem_pkg::bank_sel_t    sel;
	logic [`BANK_AW-1:0]   waddr;
	logic [`NUM_BANKS-1:0] en_vec;

	// low word bits pick the bank, the bits above pick the word
	assign sel   = req_addr_i[OFS_W +: mem_pkg::SEL_W];
	assign waddr = req_addr_i[OFS_W + mem_pkg::SEL_W +: `BANK_AW];

	assign range_err_o = (req_addr_i >= `ADDR_W'(`MEM_BYTES));

	always_comb begin
		for (int i = 0; i < `NUM_BANKS; i++) begin
			en_vec[i]           = req_i.en && !range_err_o && (sel == mem_pkg::bank_sel_t'(i));
			bank_req_o[i]       = req_i;
			bank_req_o[i].waddr = waddr;
			bank_req_o[i].en    = en_vec[i];
		end
	end

	// index of the last read, lines up with the registered bank word
	always_ff @(posedge clk) begin
		if (!rstn) begin
			sel_o <= '0;
		end else if (req_i.en && !req_i.we) begin
			sel_o <= sel;
		end
	end

	a_one_bank: assert property (@(posedge clk) disable iff (!rstn) $onehot0(en_vec))
		else $error("more than one bank enabled");

endmodule

// File: source/axi_slave_fsm.sv
// AXI-Lite slave state machine with LFSR response delay and handshake assertions
`timescale 1ns/1ps
`include "mem_defs.svh"

module axi_slave_fsm (
	input  logic                clk,
	input  logic                rstn,
	input  axi_pkg::ax_t        ar_i,
	input  logic                ar_valid_i,
	output logic                ar_ready_o,
	input  axi_pkg::ax_t        aw_i,
	input  logic                aw_valid_i,
	output logic                aw_ready_o,
	input  axi_pkg::w_t         w_i,
	input  logic                w_valid_i,
	output logic                w_ready_o,
	output axi_pkg::r_t         r_o,
	output logic                r_valid_o,
	input  logic                r_ready_i,
	output axi_pkg::b_t         b_o,
	output logic                b_valid_o,
	input  logic                b_ready_i,
	output mem_pkg::bank_req_t  req_o,
	output logic [`ADDR_W-1:0]  req_addr_o,
	input  logic                range_err_i,
	input  logic [`DATA_W-1:0]  rdata_i
);

	typedef enum logic [1:0] {
		IDLE,
		READ_WAIT,
		WRITE_WAIT
	} state_t;

	state_t     state_q;
	logic [3:0] lfsr_q;
	logic [3:0] cnt_q;       // remaining delay cycles
	logic       err_q;       // access was out of range
	logic       live_q;      // first cycle after reset done
	logic       r_valid_q;
	logic       b_valid_q;
	logic       idle;
	logic       rd_acc;
	logic       wr_acc;
	logic       rd_done;
	logic       wr_done;

	assign idle = (state_q == IDLE) && live_q;

	// read wins over a write offered in the same cycle
	assign ar_ready_o = idle;
	// aw and w only transfer as a pair
	assign aw_ready_o = idle && !ar_valid_i && (w_valid_i || !aw_valid_i);
	assign w_ready_o  = idle && !ar_valid_i && (aw_valid_i || !w_valid_i);

	assign rd_acc = ar_valid_i && ar_ready_o;
	assign wr_acc = aw_valid_i && aw_ready_o; // w_valid is implied

	// delay counter ran out, response gets latched this edge
	assign rd_done = (state_q == READ_WAIT) && !r_valid_q && (cnt_q == 4'd0);
	assign wr_done = (state_q == WRITE_WAIT) && !b_valid_q && (cnt_q == 4'd0);

	assign r_valid_o = r_valid_q;
	assign b_valid_o = b_valid_q;

	// bank access goes out in the cycle of acceptance
	always_comb begin
		req_o       = '0; // waddr is filled in by the router
		req_o.en    = rd_acc || wr_acc;
		req_o.we    = wr_acc;
		req_o.wdata = w_i.data;
		req_o.strb  = w_i.strb;
	end

	assign req_addr_o = ar_valid_i ? ar_i.addr : aw_i.addr;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q   <= IDLE;
			lfsr_q    <= `LFSR_SEED;
			cnt_q     <= 4'd0;
			err_q     <= 1'b0;
			live_q    <= 1'b0;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			live_q <= 1'b1;
			lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]}; // x^4 + x^3 + 1
			case (state_q)
				IDLE: begin
					if (rd_acc) begin
						state_q <= READ_WAIT;
						cnt_q   <= lfsr_q;
						err_q   <= range_err_i;
					end else if (wr_acc) begin
						state_q <= WRITE_WAIT;
						cnt_q   <= lfsr_q;
						err_q   <= range_err_i;
					end
				end
				READ_WAIT: begin
					if (r_valid_q) begin
						if (r_ready_i) begin
							r_valid_q <= 1'b0;
							state_q   <= IDLE;
						end
					end else if (rd_done) begin
						r_valid_q <= 1'b1;
					end else begin
						cnt_q <= cnt_q - 4'd1;
					end
				end
				WRITE_WAIT: begin
					if (b_valid_q) begin
						if (b_ready_i) begin
							b_valid_q <= 1'b0;
							state_q   <= IDLE;
						end
					end else if (wr_done) begin
						b_valid_q <= 1'b1;
					end else begin
						cnt_q <= cnt_q - 4'd1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// response payloads
	always_ff @(posedge clk) begin
		if (rd_done) begin
			r_o.data <= err_q ? '0 : rdata_i;
			r_o.resp <= err_q ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
		end
		if (wr_done) begin
			b_o.resp <= err_q ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
		end
	end

	a_one_rsp: assert property (@(posedge clk) disable iff (!rstn)
		!(r_valid_o && b_valid_o))
		else $error("r_valid and b_valid high together");

	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
		else $error("read response dropped or changed before handshake");

	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
		else $error("write response dropped or changed before handshake");

	a_lfsr_nz: assert property (@(posedge clk) disable iff (!rstn)
		lfsr_q != 4'd0)
		else $error("delay LFSR locked at zero");

endmodule

// File: source/axi_sram_top.sv
// AXI-Lite SRAM top level with slave FSM, bank router, bank array and read merge
`timescale 1ns/1ps
`include "mem_defs.svh"

module axi_sram_top (
	input  logic         clk,
	input  logic         rstn,
	input  axi_pkg::ax_t ar_i,
	input  logic         ar_valid_i,
	output logic         ar_ready_o,
	input  axi_pkg::ax_t aw_i,
	input  logic         aw_valid_i,
	output logic         aw_ready_o,
	input  axi_pkg::w_t  w_i,
	input  logic         w_valid_i,
	output logic         w_ready_o,
	output axi_pkg::r_t  r_o,
	output logic         r_valid_o,
	input  logic         r_ready_i,
	output axi_pkg::b_t  b_o,
	output logic         b_valid_o,
	input  logic         b_ready_i
);

	mem_pkg::bank_req_t                  req;
	logic [`ADDR_W-1:0]                  req_addr;
	logic                                range_err;
	mem_pkg::bank_req_t [`NUM_BANKS-1:0] bank_req;
	mem_pkg::bank_rsp_t [`NUM_BANKS-1:0] bank_rsp;
	mem_pkg::bank_sel_t                  sel;
	logic [`DATA_W-1:0]                  rdata;

	axi_slave_fsm u_fsm (
		.clk        (clk),
		.rstn       (rstn),
		.ar_i       (ar_i),
		.ar_valid_i (ar_valid_i),
		.ar_ready_o (ar_ready_o),
		.aw_i       (aw_i),
		.aw_valid_i (aw_valid_i),
		.aw_ready_o (aw_ready_o),
		.w_i        (w_i),
		.w_valid_i  (w_valid_i),
		.w_ready_o  (w_ready_o),
		.r_o        (r_o),
		.r_valid_o  (r_valid_o),
		.r_ready_i  (r_ready_i),
		.b_o        (b_o),
		.b_valid_o  (b_valid_o),
		.b_ready_i  (b_ready_i),
		.req_o      (req),
		.req_addr_o (req_addr),
		.range_err_i(range_err),
		.rdata_i    (rdata)
	);

	bank_router u_router (
		.clk        (clk),
		.rstn       (rstn),
		.req_i      (req),
		.req_addr_i (req_addr),
		.range_err_o(range_err),
		.bank_req_o (bank_req),
		.sel_o      (sel)
	);

	for (genvar g = 0; g < `NUM_BANKS; g++) begin : g_bank
		sram_bank u_bank (
			.clk  (clk),
			.req_i(bank_req[g]),
			.rsp_o(bank_rsp[g])
		);
	end

	read_merge u_merge (
		.rsp_i  (bank_rsp),
		.sel_i  (sel),
		.rdata_o(rdata)
	);

endmodule

// File: test/tb_axi_sram.sv
// testbench for the AXI-Lite SRAM with master tasks, reference memory, checking assertions, watchdog
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_axi_sram;

	localparam int MA_W   = $clog2(`MEM_BYTES);
	localparam int N_FILL = `MEM_BYTES / `STRB_W; // one write per word
	localparam int N_RW   = 32;
	localparam int N_PART = 16;
	localparam int N_OOB  = 8;
	localparam int N_BOTH = 8;
	// every transaction counted, used by the watchdog
	localparam int N_TRANS = N_FILL + 2 * N_RW + 2 * N_PART + 3 * N_OOB + 2 * N_BOTH;

	typedef logic [MA_W-1:0] maddr_t;

	logic clk;
	logic rstn;
	logic rstn_q;
	axi_pkg::ax_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_pkg::ax_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_pkg::w_t w;
	logic w_valid;
	logic w_ready;
	axi_pkg::r_t r;
	logic r_valid;
	logic r_ready;
	axi_pkg::b_t b;
	logic b_valid;
	logic b_ready;

	integer seed = 32'h0ced_ca34;
	int errors = 0;
	logic [7:0] ref_mem [`MEM_BYTES]; // expected contents, byte per entry
	logic [`DATA_W-1:0] exp_rdata;
	logic [1:0] exp_rresp;
	logic [1:0] exp_bresp;
	logic rd_open; // a read is waiting for its response
	logic wr_open;

	axi_sram_top dut0 (
		.clk(clk), .rstn(rstn),
		.ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
		.aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
		.w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
		.r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
		.b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always_ff @(posedge clk) begin
		rstn_q <= rstn; // marks the first cycle out of reset
	end

	task automatic record_fail(input string msg);
		errors++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	a_quiet_in_reset: assert property (@(posedge clk) (!rstn || !rstn_q) |->
		!r_valid && !b_valid && !ar_ready && !aw_ready && !w_ready)
		else record_fail("valid or ready high in or right after reset");
	a_ready_after_reset: assert property (@(posedge clk) rstn && !rstn_q |=>
		ar_ready && aw_ready && w_ready)
		else record_fail("readies not high in IDLE after reset");
	a_ready_after_rsp: assert property (@(posedge clk) disable iff (!rstn)
		(r_valid && r_ready) || (b_valid && b_ready) |=> ar_ready)
		else record_fail("ar_ready low after a completed response");
	a_read_rsp: assert property (@(posedge clk) disable iff (!rstn) r_valid |->
		rd_open && r.resp == exp_rresp && (exp_rresp != axi_pkg::RESP_OKAY || r.data == exp_rdata))
		else record_fail("read data or response wrong");
	a_write_rsp: assert property (@(posedge clk) disable iff (!rstn)
		b_valid |-> wr_open && b.resp == exp_bresp)
		else record_fail("write response wrong");
	a_r_stall: assert property (@(posedge clk) disable iff (!rstn)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else record_fail("read response not held under back-pressure");
	a_b_stall: assert property (@(posedge clk) disable iff (!rstn)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else record_fail("write response not held under back-pressure");
	a_busy: assert property (@(posedge clk) disable iff (!rstn)
		r_valid || b_valid |-> !ar_ready && !aw_ready && !w_ready)
		else record_fail("address accepted while a response is pending");
	a_read_first: assert property (@(posedge clk) disable iff (!rstn)
		ar_valid && aw_valid && w_valid |-> !aw_ready && !w_ready)
		else record_fail("write accepted ahead of a read");

	task automatic step();
		@(posedge clk);
		#2; // inputs change shortly after the edge
	endtask

	function automatic logic [`DATA_W-1:0] ref_word(input logic [`ADDR_W-1:0] addr);
		logic [`DATA_W-1:0] word;
		for (int k = 0; k < `STRB_W; k++) begin
			word[8*k +: 8] = ref_mem[maddr_t'(addr + k)];
		end
		return word;
	endfunction

	// word aligned address inside the given bank
	function automatic logic [`ADDR_W-1:0] rand_addr(input int bank);
		logic [`ADDR_W-1:0] rnd;
		rnd = $random(seed);
		return (rnd & (`MEM_BYTES - `NUM_BANKS * `STRB_W)) | (bank * `STRB_W);
	endfunction

	// valid shows up first, then the ready follows after a random hold
	task automatic take_rsp(input bit is_read);
		int hold;
		hold = $random(seed) & 3;
		while (!(is_read ? r_valid : b_valid)) step();
		repeat (hold) step();
		if (is_read) begin
			r_ready = 1'b1;
		end else begin
			b_ready = 1'b1;
		end
		step();
		r_ready = 1'b0;
		b_ready = 1'b0;
		rd_open = 1'b0;
		wr_open = 1'b0;
	endtask

	task automatic read_word(input logic [`ADDR_W-1:0] addr);
		exp_rdata = ref_word(addr);
		exp_rresp = (addr < `MEM_BYTES) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
		rd_open   = 1'b1;
		ar.addr   = addr;
		ar_valid  = 1'b1;
		#1;
		while (!ar_ready) begin
			step();
			#1;
		end
		step();
		ar_valid = 1'b0;
		take_rsp(1'b1);
	endtask

	task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
			input logic [`STRB_W-1:0] strb);
		exp_bresp = (addr < `MEM_BYTES) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
		wr_open   = 1'b1;
		for (int k = 0; k < `STRB_W; k++) begin
			if (strb[k] && addr < `MEM_BYTES) ref_mem[maddr_t'(addr + k)] = data[8*k +: 8];
		end
		aw.addr  = addr;
		w.data   = data;
		w.strb   = strb;
		aw_valid = 1'b1;
		w_valid  = 1'b1;
		#1;
		while (!(aw_ready && w_ready)) begin
			step();
			#1;
		end
		step();
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		take_rsp(1'b0);
	endtask

	initial begin
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		rstn = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		r_ready = 1'b0;
		b_ready = 1'b0;
		rd_open = 1'b0;
		wr_open = 1'b0;
		repeat (5) @(posedge clk);
		#2 rstn = 1'b1;
		step();
		step();
		for (int i = 0; i < N_FILL; i++) begin
			addr = i * `STRB_W;
			write_word(addr, addr * 32'h9e37_79b9 + 32'h1234_5678, '1);
		end
		for (int i = 0; i < N_RW; i++) begin // full word, every bank in turn
			addr = rand_addr(i % `NUM_BANKS);
			write_word(addr, $random(seed), '1);
			read_word(addr);
		end
		for (int i = 0; i < N_PART; i++) begin
			addr = rand_addr(i % `NUM_BANKS);
			write_word(addr, $random(seed), `STRB_W'($random(seed)));
			read_word(addr);
		end
		for (int i = 0; i < N_OOB; i++) begin
			addr = (i == 0) ? 0 : rand_addr(i % `NUM_BANKS);
			addr = addr + `MEM_BYTES * (1 + i * 37);
			write_word(addr, $random(seed), '1);
			read_word(addr);
			read_word(addr % `MEM_BYTES); // aliased word must be untouched
		end
		for (int i = 0; i < N_BOTH; i++) begin
			addr = rand_addr(i % `NUM_BANKS);
			data = $random(seed);
			aw.addr  = addr;
			w.data   = data;
			w.strb   = '1;
			aw_valid = 1'b1;
			w_valid  = 1'b1;
			read_word(addr); // sees the old word
			write_word(addr, data, '1);
		end
		step();
		$display("closing: %0d errors", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(N_TRANS * 40 * 20 + 2000);
		$display("timeout: the run did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: all.f
+incdir+source
source/axi_pkg.sv
source/mem_pkg.sv
source/sram_bank.sv
source/read_merge.sv
source/bank_router.sv
source/axi_slave_fsm.sv
source/axi_sram_top.sv
test/tb_axi_sram.sv

// File: run.sh
#!/bin/sh
# compile and run the AXI-Lite SRAM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_axi_sram -o tb_axi_sram

out="$(./obj_dir/tb_axi_sram)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
